// File: hdl/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define XLEN      32
`define REG_AW    5
`define NUM_REGS  32
`define RESET_PC  32'h8000_0000
`define WMASK_W   4

// major opcodes, inst[6:0]
`define OPC_OP_IMM  7'b001_0011
`define OPC_LUI     7'b011_0111
`define OPC_AUIPC   7'b001_0111
`define OPC_JAL     7'b110_1111
`define OPC_JALR    7'b110_0111
`define OPC_LOAD    7'b000_0011
`define OPC_STORE   7'b010_0011
`define OPC_SYSTEM  7'b111_0011

// load/store width codes, funct3
`define F3_B   3'b000
`define F3_H   3'b001
`define F3_W   3'b010
`define F3_BU  3'b100
`define F3_HU  3'b101

`endif

// File: hdl/rv_pkg.sv
`include "rv_consts.svh"

package rv_pkg;

  typedef logic [`XLEN-1:0]   word_t;
  typedef logic [`REG_AW-1:0] reg_addr_t;

  // funct3 passed straight through to the load/store unit
  typedef logic [2:0] mem_size_t;

  typedef enum logic [3:0] {
    OP_ALU_IMM,  // whole OP-IMM group runs as add
    OP_LUI,
    OP_AUIPC,
    OP_JAL,
    OP_JALR,
    OP_LOAD,
    OP_STORE,
    OP_HALT,     // ebreak
    OP_NOP
  } op_class_t;

  // one decoded instruction, consumed in the same cycle
  typedef struct packed {
    op_class_t cls;
    reg_addr_t rd;
    mem_size_t size;
    word_t     imm;
    logic      use_pc;   // adder operand a is pc, not rs1
    logic      reg_wen;
  } dec_op_t;

endpackage

// File: hdl/rv_decode_if.sv
`timescale 1ns/1ps

// decoded operation plus register read addresses, no handshake
interface rv_decode_if;

  rv_pkg::dec_op_t   op;
  rv_pkg::reg_addr_t rs1_addr;
  rv_pkg::reg_addr_t rs2_addr;

  modport dec (
    output op,
    output rs1_addr,
    output rs2_addr
  );

  modport exe (
    input op
  );

  modport rf (
    input rs1_addr,
    input rs2_addr
  );

endinterface

// File: hdl/rv_decoder.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_decoder (
  input  rv_pkg::word_t inst,
  rv_decode_if.dec      dec
);
  import rv_pkg::*;

  logic [6:0] opcode;
  reg_addr_t  rd;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  reg_addr_t  rs1_sel;
  mem_size_t  funct3;
  logic       is_ebreak;

  word_t imm_i;
  word_t imm_s;
  word_t imm_j;
  word_t imm_u;

  dec_op_t op;

  // fixed field positions
  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  // sign-extended immediates
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_u = {inst[31:12], 12'h000};  // already shifted

  // ecall shares the opcode, only funct12 == 1 halts
  assign is_ebreak = (inst[31:20] == 12'h001) && (rs1 == '0) && (funct3 == 3'b000) && (rd == '0);

  always_comb begin
    op.cls    = OP_NOP;
    op.rd     = rd;
    op.size   = funct3;
    op.imm    = imm_i;
    op.use_pc = 1'b0;
    rs1_sel   = rs1;

    case (opcode)
      `OPC_OP_IMM: op.cls = OP_ALU_IMM;
      `OPC_LUI: begin
        op.cls  = OP_LUI;
        op.imm  = imm_u;
        rs1_sel = '0;  // x0 gives a zero first operand
      end
      `OPC_AUIPC: begin
        op.cls    = OP_AUIPC;
        op.imm    = imm_u;
        op.use_pc = 1'b1;
      end
      `OPC_JAL: begin
        op.cls    = OP_JAL;
        op.imm    = imm_j;
        op.use_pc = 1'b1;
      end
      `OPC_JALR:  op.cls = OP_JALR;
      `OPC_LOAD:  op.cls = OP_LOAD;
      `OPC_STORE: begin
        op.cls = OP_STORE;
        op.imm = imm_s;
      end
      `OPC_SYSTEM: begin
        if (is_ebreak) begin
          op.cls = OP_HALT;
        end
      end
      default: op.cls = OP_NOP;  // unknown opcode just steps pc
    endcase

    // everything writes rd except these
    op.reg_wen = !((op.cls == OP_STORE) || (op.cls == OP_HALT) || (op.cls == OP_NOP));
  end

  assign dec.op       = op;
  assign dec.rs1_addr = rs1_sel;
  assign dec.rs2_addr = rs2;

endmodule

// File: hdl/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_regfile (
  input  logic              clk,
  rv_decode_if.rf           rd_if,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  logic              wb_en,
  input  rv_pkg::reg_addr_t wb_addr,
  input  rv_pkg::word_t     wb_data
);
  import rv_pkg::*;

  word_t regs [`NUM_REGS];

  logic wr_ok;

  // x0 is hardwired
  assign wr_ok = wb_en && (wb_addr != '0);

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      regs[wb_addr] <= wb_data;
    end
  end

  // async read ports, entry 0 masked
  assign rs1_data = (rd_if.rs1_addr == '0) ? '0 : regs[rd_if.rs1_addr];
  assign rs2_data = (rd_if.rs2_addr == '0) ? '0 : regs[rd_if.rs2_addr];

endmodule

// File: hdl/rv_exec_lsu.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_exec_lsu (
  input  logic                clk,
  input  logic                rst_n,
  rv_decode_if.exe            dec,
  input  rv_pkg::word_t       rs1_data,
  input  rv_pkg::word_t       rs2_data,
  output rv_pkg::word_t       pc,
  output logic                halt,
  output logic                wb_en,
  output rv_pkg::reg_addr_t   wb_addr,
  output rv_pkg::word_t       wb_data,
  output rv_pkg::word_t       mem_addr,
  output logic                mem_ren,
  output logic                mem_wen,
  output rv_pkg::word_t       mem_wdata,
  output logic [`WMASK_W-1:0] mem_wmask,
  input  rv_pkg::word_t       mem_rdata
);
  import rv_pkg::*;

  word_t add_a;
  word_t sum;
  word_t pc_seq;
  word_t pc_next;
  word_t lane;     // rdata shifted down to the addressed byte
  word_t ld_data;
  logic [1:0] offs;
  logic is_jump;
  logic is_load;
  logic is_store;
  logic [`WMASK_W-1:0] base_mask;

  assign is_jump  = (dec.op.cls == OP_JAL) || (dec.op.cls == OP_JALR);
  assign is_load  = (dec.op.cls == OP_LOAD);
  assign is_store = (dec.op.cls == OP_STORE);

  // single adder shared by every class
  assign add_a  = dec.op.use_pc ? pc : rs1_data;
  assign sum    = add_a + dec.op.imm;
  assign pc_seq = pc + word_t'(4);
  assign offs   = sum[1:0];

  always_comb begin
    case (dec.op.cls)
      OP_JAL:  pc_next = sum;
      OP_JALR: pc_next = {sum[`XLEN-1:1], 1'b0};
      OP_HALT: pc_next = pc;  // stay on the ebreak
      default: pc_next = pc_seq;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc   <= `RESET_PC;
      halt <= 1'b0;
    end else if (!halt) begin  // frozen until reset
      pc   <= pc_next;
      halt <= (dec.op.cls == OP_HALT);
    end
  end

  // load extract and extend
  assign lane = mem_rdata >> {offs, 3'b000};

  always_comb begin
    ld_data = '0;  // misaligned reads return zero
    case (dec.op.size)
      `F3_B:  ld_data = {{24{lane[7]}}, lane[7:0]};
      `F3_BU: ld_data = {24'h00_0000, lane[7:0]};
      `F3_H: begin
        if (!offs[0]) begin
          ld_data = {{16{lane[15]}}, lane[15:0]};
        end
      end
      `F3_HU: begin
        if (!offs[0]) begin
          ld_data = {16'h0000, lane[15:0]};
        end
      end
      `F3_W: begin
        if (offs == 2'b00) begin
          ld_data = lane;
        end
      end
      default: ld_data = '0;
    endcase
  end

  // store byte enables before shifting into place
  always_comb begin
    case (dec.op.size)
      `F3_B:   base_mask = 4'b0001;
      `F3_H:   base_mask = offs[0] ? 4'b0000 : 4'b0011;
      `F3_W:   base_mask = (offs == 2'b00) ? 4'b1111 : 4'b0000;
      default: base_mask = 4'b0000;
    endcase
  end

  assign mem_addr  = sum;
  assign mem_ren   = is_load && !halt;
  assign mem_wen   = is_store && !halt;
  assign mem_wdata = rs2_data << {offs, 3'b000};
  assign mem_wmask = mem_wen ? (base_mask << offs) : '0;

  // write-back
  assign wb_en   = dec.op.reg_wen && !halt;
  assign wb_addr = dec.op.rd;

  always_comb begin
    if (is_jump) begin
      wb_data = pc_seq;  // link address
    end else if (is_load) begin
      wb_data = ld_data;
    end else begin
      wb_data = sum;
    end
  end

endmodule

// File: hdl/rv_core_top.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_top (
  input  logic                clk,
  input  logic                rst_n,
  input  rv_pkg::word_t       inst,
  input  rv_pkg::word_t       mem_rdata,
  output rv_pkg::word_t       pc,
  output rv_pkg::word_t       mem_addr,
  output logic                mem_ren,
  output logic                mem_wen,
  output rv_pkg::word_t       mem_wdata,
  output logic [`WMASK_W-1:0] mem_wmask,
  output logic                halt
);
  import rv_pkg::*;

  word_t     rs1_data;
  word_t     rs2_data;
  logic      wb_en;
  reg_addr_t wb_addr;
  word_t     wb_data;

  rv_decode_if dec_bus ();

  rv_decoder u_decoder (
    .inst (inst),
    .dec  (dec_bus)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rd_if    (dec_bus),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb_en    (wb_en),
    .wb_addr  (wb_addr),
    .wb_data  (wb_data)
  );

  rv_exec_lsu u_exec (
    .clk       (clk),
    .rst_n     (rst_n),
    .dec       (dec_bus),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .pc        (pc),
    .halt      (halt),
    .wb_en     (wb_en),
    .wb_addr   (wb_addr),
    .wb_data   (wb_data),
    .mem_addr  (mem_addr),
    .mem_ren   (mem_ren),
    .mem_wen   (mem_wen),
    .mem_wdata (mem_wdata),
    .mem_wmask (mem_wmask),
    .mem_rdata (mem_rdata)
  );

endmodule

// File: testbench/rv_checker.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_checker (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] inst,
  input  logic [31:0] pc,
  input  logic [31:0] mem_addr,
  input  logic        mem_ren,
  input  logic        mem_wen,
  input  logic [31:0] mem_wdata,
  input  logic [3:0]  mem_wmask,
  input  logic        halt,
  input  logic [31:0] tdata [256],
  output logic        done,
  output int          fail_cnt
);

  localparam int TRACE_SLOT = 'h60;
  localparam int JUMP_SLOT  = 'hC0;
  localparam int HALT_SLOT  = 'hFF;

  int   test_cnt;
  int   st_idx;
  int   jmp_idx;
  int   ld_cnt;
  int   late_stores;
  int   cyc;
  logic jump_pending;
  logic ok;

  task automatic check_word(input string name, input logic [31:0] exp,
                            input logic [31:0] act, inout logic good);
    if (exp !== act) begin
      $display("mismatch %s expected %08h got %08h", name, exp, act);
      good = 1'b0;
    end
  endtask

  task automatic finish_test(input string what, input logic good);
    test_cnt++;
    if (!good) begin
      fail_cnt++;
    end
    $display("test %0d %s: %s", test_cnt, what, good ? "ok" : "failed");
  endtask

  // data bits covered by the enabled byte lanes
  function automatic logic [31:0] lane_bits(input logic [3:0] mask);
    logic [31:0] bits;
    for (int b = 0; b < 4; b++) begin
      bits[8*b +: 8] = {8{mask[b]}};
    end
    return bits;
  endfunction

  // one sampled edge: jump target, read enable and store port
  task automatic check_cycle();
    logic good;
    logic exp_ren;
    int   base;
    logic [31:0] lanes;
    if (jump_pending) begin
      jump_pending = 1'b0;
      good = 1'b1;
      if (jmp_idx >= int'(tdata[JUMP_SLOT])) begin
        $display("jump taken beyond the expected jump list");
        good = 1'b0;
      end else begin
        check_word("pc", tdata[JUMP_SLOT + 1 + jmp_idx], pc, good);
      end
      jmp_idx++;
      finish_test($sformatf("jump %0d target", jmp_idx), good);
    end
    if (!halt && (inst[6:0] == `OPC_JAL || inst[6:0] == `OPC_JALR)) begin
      jump_pending = 1'b1;
    end
    exp_ren = !halt && (inst[6:0] == `OPC_LOAD);  // loads read, nothing else
    if (exp_ren || mem_ren) begin
      good = 1'b1;
      ld_cnt++;
      check_word("mem_ren", {31'h0, exp_ren}, {31'h0, mem_ren}, good);
      finish_test($sformatf("load %0d read enable", ld_cnt), good);
    end
    if (mem_wen) begin
      good = 1'b1;
      if (halt) begin
        late_stores++;
      end
      if (st_idx >= int'(tdata[TRACE_SLOT])) begin
        $display("store at %08h beyond the expected trace", mem_addr);
        good = 1'b0;
      end else begin
        base  = TRACE_SLOT + 1 + 3 * st_idx;
        lanes = lane_bits(tdata[base + 2][3:0]);  // unwritten lanes carry no data
        check_word("mem_addr", tdata[base], mem_addr, good);
        check_word("mem_wdata", tdata[base + 1] & lanes, mem_wdata & lanes, good);
        check_word("mem_wmask", tdata[base + 2], {28'h0, mem_wmask}, good);
      end
      st_idx++;
      finish_test($sformatf("store %0d", st_idx), good);
    end
  endtask

  initial begin
    done = 1'b0;
    fail_cnt = 0;
    test_cnt = 0;
    st_idx = 0;
    jmp_idx = 0;
    ld_cnt = 0;
    late_stores = 0;
    jump_pending = 1'b0;

    @(posedge clk);  // first edge loads the reset values
    ok = 1'b1;
    cyc = 0;
    while (!rst_n && cyc < 50) begin
      @(posedge clk);
      cyc++;
      if (!rst_n) begin
        check_word("pc", `RESET_PC, pc, ok);
        check_word("halt", 32'h0, {31'h0, halt}, ok);
        check_word("mem_wen", 32'h0, {31'h0, mem_wen}, ok);
      end
    end
    if (!rst_n) begin
      $display("reset was never released within 50 cycles");
      ok = 1'b0;
    end
    // first edge out of reset, pc not yet advanced
    check_word("pc", `RESET_PC, pc, ok);
    check_word("halt", 32'h0, {31'h0, halt}, ok);
    check_word("mem_wen", 32'h0, {31'h0, mem_wen}, ok);
    finish_test("reset values", ok);
    check_cycle();

    cyc = 0;
    while (!halt && cyc < 500) begin
      @(posedge clk);
      check_cycle();
      cyc++;
    end

    ok = 1'b1;
    if (!halt) begin
      $display("halt never asserted within 500 cycles");
      ok = 1'b0;
    end else begin
      check_word("pc", tdata[HALT_SLOT], pc, ok);
    end
    finish_test("halt", ok);

    if (halt) begin
      repeat (10) begin
        @(posedge clk);
        check_cycle();
      end
      ok = (late_stores == 0);
      if (!ok) begin
        $display("%0d stores seen after halt", late_stores);
      end
      finish_test("quiet after halt", ok);
    end

    ok = 1'b1;
    check_word("store count", tdata[TRACE_SLOT], st_idx, ok);
    check_word("jump count", tdata[JUMP_SLOT], jmp_idx, ok);
    finish_test("trace complete", ok);

    $display("tests %0d, passed %0d, failed %0d", test_cnt, test_cnt - fail_cnt, fail_cnt);
    done = 1'b1;
  end

endmodule

// File: testbench/tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_rv_core;
  import rv_pkg::*;

  localparam logic [31:0] DATA_BASE = 32'h0000_1000;
  localparam int PROG_WORDS = 64;
  localparam int DATA_SLOT  = 'h40;  // data image inside the file array
  localparam int DMEM_WORDS = 32;
  localparam logic [31:0] STORE_AFTER_HALT = 32'h0020_A023;  // sw x2, 0(x1)

  logic  clk = 1'b0;
  logic  rst_n;
  word_t inst = '0;
  word_t mem_rdata;
  word_t pc;
  word_t mem_addr;
  logic  mem_ren;
  logic  mem_wen;
  word_t mem_wdata;
  logic [`WMASK_W-1:0] mem_wmask;
  logic  halt;

  logic [31:0] tdata [256];
  logic [31:0] dmem [DMEM_WORDS];
  logic done;
  int   fail_cnt;
  int   wait_cyc;

  always #2 clk = ~clk;  // 4 ns period

  function automatic int dmem_index(input logic [31:0] addr);
    logic [31:0] offs;
    offs = addr - DATA_BASE;
    return int'(offs[6:2]);
  endfunction

  function automatic logic [31:0] fetch(input logic [31:0] addr);
    logic [31:0] offs;
    offs = (addr - `RESET_PC) >> 2;
    if (offs < PROG_WORDS) begin
      return tdata[offs];
    end
    return 32'h0000_0000;  // outside the program, opcode 0 is a nop
  endfunction

  // combinational read of the aligned word
  always_comb begin
    mem_rdata = mem_ren ? dmem[dmem_index(mem_addr)] : '0;
  end

  always @(posedge clk) begin
    if (mem_wen) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_wmask[b]) begin
          dmem[dmem_index(mem_addr)][8*b +: 8] <= mem_wdata[8*b +: 8];
        end
      end
    end
  end

  // next instruction shortly after the edge
  always @(posedge clk) begin
    #1;
    inst <= halt ? STORE_AFTER_HALT : fetch(pc);  // a halted core must drop this store
  end

  rv_core_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .inst      (inst),
    .mem_rdata (mem_rdata),
    .pc        (pc),
    .mem_addr  (mem_addr),
    .mem_ren   (mem_ren),
    .mem_wen   (mem_wen),
    .mem_wdata (mem_wdata),
    .mem_wmask (mem_wmask),
    .halt      (halt)
  );

  rv_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .inst      (inst),
    .pc        (pc),
    .mem_addr  (mem_addr),
    .mem_ren   (mem_ren),
    .mem_wen   (mem_wen),
    .mem_wdata (mem_wdata),
    .mem_wmask (mem_wmask),
    .halt      (halt),
    .tdata     (tdata),
    .done      (done),
    .fail_cnt  (fail_cnt)
  );

  initial begin
    rst_n = 1'b0;
    for (int i = 0; i < 256; i++) begin
      tdata[i] = '0;
    end
    $readmemh("testbench/rv_testdata.hex", tdata);
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = tdata[DATA_SLOT + i];
    end

    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;

    wait_cyc = 0;
    while (!done && wait_cyc < 2000) begin
      @(posedge clk);
      wait_cyc++;
    end

    if (done && fail_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      if (!done) begin
        $display("checker did not finish within 2000 cycles");
      end
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+hdl
hdl/rv_pkg.sv
hdl/rv_decode_if.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_exec_lsu.sv
hdl/rv_core_top.sv
testbench/rv_checker.sv
testbench/tb_rv_core.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run into sim.log, decide by the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_rv_core -o tb_rv_core \
  && ./obj_dir/tb_rv_core > sim.log 2>&1 \
  || echo "build or simulation step failed"

if [ -f sim.log ]; then
  cat sim.log
fi

grep -q "^RESULT: PASS$" sim.log 2>/dev/null && exit 0 || exit 1

// File: testbench/rv_testdata.hex
// @00 program words from pc 0x80000000, @40 data words from 0x1000
// @60 store count, then addr data mask per store; @C0 jump count, targets; @FF halt pc
@00
000010B7 12300113 FFF10193 ABCDE237 00001297
0220A023 0230A223 0240A423 0250A623
0080036F 0200AE23 011303E7 0200AE23 0200AE23
0260A823 0270AA23
00008403 0480A023 00108403 0480A023 00208403 0480A023 00308403 0480A023
0000C403 0480A023 0010C403 0480A023 0020C403 0480A023 0030C403 0480A023
00009403 0480A023 00209403 0480A023
0000D403 0480A023 0020D403 0480A023
0000A403 0480A023
112234B7 34448493
04908823 049088A3 04908923 049089A3
04909A23 04909B23
00100073
@40
F1E2D3C4
@60
00000019
00001020 00000123 0000000F
00001024 00000122 0000000F
00001028 ABCDE000 0000000F
0000102C 80001010 0000000F
00001030 80000028 0000000F
00001034 80000030 0000000F
00001040 FFFFFFC4 0000000F
00001040 FFFFFFD3 0000000F
00001040 FFFFFFE2 0000000F
00001040 FFFFFFF1 0000000F
00001040 000000C4 0000000F
00001040 000000D3 0000000F
00001040 000000E2 0000000F
00001040 000000F1 0000000F
00001040 FFFFD3C4 0000000F
00001040 FFFFF1E2 0000000F
00001040 0000D3C4 0000000F
00001040 0000F1E2 0000000F
00001040 F1E2D3C4 0000000F
00001050 00000044 00000001
00001051 22334400 00000002
00001052 33440000 00000004
00001053 44000000 00000008
00001054 11223344 00000003
00001056 33440000 0000000C
@C0
00000002 8000002C 80000038
@FF
800000C8
